/* common/muldiv_params.svh */
// -------------------------------------------------
// widths and iteration count for the mul/div unit
// MULDIV_CNT_W must hold MULDIV_ITERS - 1
// -------------------------------------------------
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// operand width, one processor word
`define MULDIV_XLEN 32

// full product or rem/quot pair
`define MULDIV_RLEN (2 * `MULDIV_XLEN)

// one iteration per operand bit, for both engines
`define MULDIV_ITERS `MULDIV_XLEN

// iteration counter width in the control units
`define MULDIV_CNT_W 6

`endif

/* common/muldiv_fn_pkg.sv */
// -------------------------------------------------
// operation select for a mul/div request
// code 3 is unused and is steered to the divider
// -------------------------------------------------
package muldiv_fn_pkg;

  // ------------------------------------------------
  // operation codes
  // ------------------------------------------------

  // FN_MUL   signed 32x32 multiply, full 64-bit product
  // FN_DIV   signed divide, quotient and remainder
  // FN_DIVU  unsigned divide, quotient and remainder
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_t;

endpackage

/* common/muldiv_result_pkg.sv */
// -------------------------------------------------
// response word of the mul/div unit
// multiply fills product, divide fills pair
// -------------------------------------------------
package muldiv_result_pkg;

  `include "muldiv_params.svh"

  // ------------------------------------------------
  // divide view
  // ------------------------------------------------

  // remainder sits in the upper half, quotient in the lower
  typedef struct packed {
    logic [`MULDIV_XLEN-1:0] rem;
    logic [`MULDIV_XLEN-1:0] quot;
  } muldiv_pair_t;

  // ------------------------------------------------
  // response word, two readings of the same bits
  // ------------------------------------------------

  typedef union packed {
    logic [`MULDIV_RLEN-1:0] product;
    muldiv_pair_t            pair;
  } muldiv_result_t;

endpackage

/* mul/int_mul_iterative.sv */
// -------------------------------------------------
// iterative signed multiplier that handles one bit per cycle
// 32 cycles from request transfer to response
// -------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_params.svh"

module int_mul_iterative import muldiv_result_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`MULDIV_XLEN-1:0] a,
  input  logic [`MULDIV_XLEN-1:0] b,
  input  logic                    req_val,
  output logic                    req_rdy,
  output muldiv_result_t          result,
  output logic                    resp_val,
  input  logic                    resp_rdy
);

  // strobes from control to datapath
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;

  // accumulator, shift registers and sign fix-up
  int_mul_iterative_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .a         (a),
    .b         (b),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel),
    .result    (result)
  );

  // decides load vs shift each cycle
  int_mul_iterative_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel)
  );

endmodule

// -------------------------------------------------
// datapath
// -------------------------------------------------

module int_mul_iterative_dpath import muldiv_result_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`MULDIV_XLEN-1:0] a,
  input  logic [`MULDIV_XLEN-1:0] b,
  input  logic                    a_en,
  input  logic                    a_mux_sel,
  input  logic                    b_en,
  input  logic                    b_mux_sel,
  output muldiv_result_t          result
);

  localparam int XLEN = `MULDIV_XLEN;
  localparam int RLEN = `MULDIV_RLEN;

  // multiplicand widens as it shifts left
  logic [RLEN-1:0] a_reg;
  // multiplier bits are consumed from the low end
  logic [XLEN-1:0] b_reg;
  logic [RLEN-1:0] acc_reg;
  logic            sign_a_reg;
  logic            sign_b_reg;

  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [RLEN-1:0] a_mux_out;
  logic [XLEN-1:0] b_mux_out;
  logic [RLEN-1:0] acc_next;
  logic [RLEN-1:0] acc_neg;

  // most negative maps onto 2^31 which still fits unsigned
  assign a_mag = a[XLEN-1] ? -a : a;
  assign b_mag = b[XLEN-1] ? -b : b;

  // load takes fresh magnitudes, shift walks one bit
  assign a_mux_out = a_mux_sel ? (a_reg << 1) : {{XLEN{1'b0}}, a_mag};
  assign b_mux_out = b_mux_sel ? (b_reg >> 1) : b_mag;

  // add the shifted multiplicand when this multiplier bit is set
  assign acc_next = b_reg[0] ? (acc_reg + a_reg) : acc_reg;

  // operand shifters
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
  end

  // accumulator and saved signs
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_reg    <= '0;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (a_en && !a_mux_sel) begin
      // load cycle
      acc_reg    <= '0;
      sign_a_reg <= a[XLEN-1];
      sign_b_reg <= b[XLEN-1];
    end else if (a_en) begin
      acc_reg <= acc_next;
    end
  end

  // negate when exactly one operand was negative
  assign acc_neg        = -acc_reg;
  assign result.product = (sign_a_reg ^ sign_b_reg) ? acc_neg : acc_reg;

endmodule

// -------------------------------------------------
// control
// -------------------------------------------------

module int_mul_iterative_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel
);

  localparam int CNT_W = `MULDIV_CNT_W;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`MULDIV_ITERS - 1);

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] CALC = 2'd1;
  localparam logic [1:0] DONE = 2'd2;

  logic [1:0]       state;
  logic [CNT_W-1:0] count;
  logic             req_go;
  logic             resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // last shift happens on the edge that leaves CALC
          if (count == LAST) begin
            state <= DONE;
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // hold the product until the consumer takes it
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
          count <= '0;
        end
      endcase
    end
  end

  always_comb begin
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    a_en      = 1'b0;
    a_mux_sel = 1'b0;
    b_en      = 1'b0;
    b_mux_sel = 1'b0;
    case (state)
      IDLE: begin
        // req_rdy is high here so req_val marks the transfer
        req_rdy = 1'b1;
        a_en    = req_val;
        b_en    = req_val;
      end
      CALC: begin
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
        b_en      = 1'b1;
        b_mux_sel = 1'b1;
      end
      DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        resp_val = 1'b0;
      end
    endcase
  end

endmodule

/* div/int_div_iterative.sv */
// -------------------------------------------------
// iterative restoring divider, signed or unsigned
// 32 cycles from request transfer to response
// -------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_params.svh"

module int_div_iterative import muldiv_result_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`MULDIV_XLEN-1:0] a,
  input  logic [`MULDIV_XLEN-1:0] b,
  input  logic                    is_signed,
  input  logic                    req_val,
  output logic                    req_rdy,
  output muldiv_result_t          result,
  output logic                    resp_val,
  input  logic                    resp_rdy
);

  logic load_en;
  logic step_en;

  // remainder/quotient pair and sign fix-up
  int_div_iterative_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .a         (a),
    .b         (b),
    .is_signed (is_signed),
    .load_en   (load_en),
    .step_en   (step_en),
    .result    (result)
  );

  // same IDLE/CALC/DONE sequencing as the multiplier
  int_div_iterative_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load_en  (load_en),
    .step_en  (step_en)
  );

endmodule

// -------------------------------------------------
// datapath
// -------------------------------------------------

module int_div_iterative_dpath import muldiv_result_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`MULDIV_XLEN-1:0] a,
  input  logic [`MULDIV_XLEN-1:0] b,
  input  logic                    is_signed,
  input  logic                    load_en,
  input  logic                    step_en,
  output muldiv_result_t          result
);

  localparam int XLEN = `MULDIV_XLEN;

  logic [XLEN-1:0] rem_reg;
  // dividend bits shift out the top while quotient bits enter the bottom
  logic [XLEN-1:0] quot_reg;
  logic [XLEN-1:0] div_reg;
  // signs are only kept for a signed operation
  logic            sign_a_reg;
  logic            sign_b_reg;
  logic            dz_reg;

  logic            neg_a;
  logic            neg_b;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [XLEN:0]   rem_shift;
  logic [XLEN+1:0] trial;
  logic            trial_ok;
  logic [XLEN-1:0] quot_out;
  logic [XLEN-1:0] rem_out;

  // unsigned operations keep the raw bits
  assign neg_a = is_signed && a[XLEN-1];
  assign neg_b = is_signed && b[XLEN-1];
  assign a_mag = neg_a ? -a : a;
  assign b_mag = neg_b ? -b : b;

  // shift the pair left one, then try the subtract
  assign rem_shift = {rem_reg, quot_reg[XLEN-1]};
  assign trial     = {1'b0, rem_shift} - {2'b00, div_reg};
  // borrow out means the divisor did not fit
  assign trial_ok  = !trial[XLEN+1];

  // working registers
  always_ff @(posedge clk) begin
    if (load_en) begin
      rem_reg  <= '0;
      quot_reg <= a_mag;
      div_reg  <= b_mag;
    end else if (step_en) begin
      // remainder stays below the divisor so the low bits suffice
      rem_reg  <= trial_ok ? trial[XLEN-1:0] : rem_shift[XLEN-1:0];
      quot_reg <= {quot_reg[XLEN-2:0], trial_ok};
    end
  end

  // sign and divide-by-zero flags
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
      dz_reg     <= 1'b0;
    end else if (load_en) begin
      sign_a_reg <= neg_a;
      sign_b_reg <= neg_b;
      dz_reg     <= (b == '0);
    end
  end

  // ------------------------------------------------
  // result sign rules
  // ------------------------------------------------

  // quotient truncates toward zero, all ones on divide by zero
  // most negative / -1 lands on 2^31 which reads back as the dividend
  always_comb begin
    if (dz_reg) begin
      quot_out = '1;
    end else if (sign_a_reg ^ sign_b_reg) begin
      quot_out = -quot_reg;
    end else begin
      quot_out = quot_reg;
    end
  end

  // remainder follows the dividend, which also gives the dividend back on /0
  assign rem_out = sign_a_reg ? -rem_reg : rem_reg;

  always_comb begin
    result.pair.rem  = rem_out;
    result.pair.quot = quot_out;
  end

endmodule

// -------------------------------------------------
// control
// -------------------------------------------------

module int_div_iterative_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load_en,
  output logic step_en
);

  localparam int CNT_W = `MULDIV_CNT_W;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`MULDIV_ITERS - 1);

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] CALC = 2'd1;
  localparam logic [1:0] DONE = 2'd2;

  logic [1:0]       state;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_val) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // one quotient bit per cycle
          if (count == LAST) begin
            state <= DONE;
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          if (resp_rdy) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
          count <= '0;
        end
      endcase
    end
  end

  // rdy is high in IDLE and val in DONE, so val alone marks each transfer
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign load_en  = req_rdy && req_val;
  assign step_en  = (state == CALC);

endmodule

/* logic/muldiv_unit.sv */
// -------------------------------------------------
// one operation in flight, no overlap between ops
// no registers on the request or response path
// -------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_params.svh"

module muldiv_unit import muldiv_fn_pkg::*, muldiv_result_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  muldiv_fn_t              req_fn,
  input  logic [`MULDIV_XLEN-1:0] req_a,
  input  logic [`MULDIV_XLEN-1:0] req_b,
  input  logic                    req_val,
  output logic                    req_rdy,
  output muldiv_result_t          resp_result,
  output logic                    resp_val,
  input  logic                    resp_rdy
);

  // owner of the current op, 1 means divider
  logic owner_reg;
  logic busy_reg;

  logic           sel_div;
  logic           mul_req_val;
  logic           mul_req_rdy;
  logic           mul_resp_val;
  logic           mul_resp_rdy;
  muldiv_result_t mul_result;
  logic           div_req_val;
  logic           div_req_rdy;
  logic           div_resp_val;
  logic           div_resp_rdy;
  muldiv_result_t div_result;

  // ------------------------------------------------
  // request steering
  // ------------------------------------------------

  assign sel_div     = (req_fn != FN_MUL);
  assign mul_req_val = req_val && !busy_reg && !sel_div;
  assign div_req_val = req_val && !busy_reg && sel_div;
  assign req_rdy     = !busy_reg && (sel_div ? div_req_rdy : mul_req_rdy);

  // ------------------------------------------------
  // response return, only the owner sees resp_rdy
  // ------------------------------------------------

  assign resp_result  = owner_reg ? div_result : mul_result;
  assign resp_val     = owner_reg ? div_resp_val : mul_resp_val;
  assign mul_resp_rdy = resp_rdy && !owner_reg;
  assign div_resp_rdy = resp_rdy && owner_reg;

  // busy from request transfer to response transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_reg  <= 1'b0;
      owner_reg <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy_reg  <= 1'b1;
      owner_reg <= sel_div;
    end else if (resp_val && resp_rdy) begin
      busy_reg <= 1'b0;
    end
  end

  int_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .a        (req_a),
    .b        (req_b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .result   (mul_result),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  // signed flag only matters on the load cycle
  int_div_iterative div (
    .clk       (clk),
    .reset     (reset),
    .a         (req_a),
    .b         (req_b),
    .is_signed (req_fn == FN_DIV),
    .req_val   (div_req_val),
    .req_rdy   (div_req_rdy),
    .result    (div_result),
    .resp_val  (div_resp_val),
    .resp_rdy  (div_resp_rdy)
  );

endmodule

/* tb/muldiv_properties.sv */
// -------------------------------------------------
// handshake checks on the mul/div top level
// attached to muldiv_unit by bind
// -------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_params.svh"

module muldiv_properties (
  input logic                    clk,
  input logic                    reset,
  input logic                    req_val,
  input logic                    req_rdy,
  input logic [`MULDIV_RLEN-1:0] resp_result,
  input logic                    resp_val,
  input logic                    resp_rdy
);

  localparam logic [`MULDIV_CNT_W-1:0] SAT = `MULDIV_CNT_W'(`MULDIV_ITERS);

  // cycles since the last request transfer, parks at SAT
  logic [`MULDIV_CNT_W-1:0] since_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      since_req <= SAT;
    end else if (req_val && req_rdy) begin
      since_req <= '0;
    end else if (since_req < SAT) begin
      since_req <= since_req + 1'b1;
    end
  end

  // --------------------------------------------------
  // assertions
  // --------------------------------------------------

  // one op in flight, so no request while a response waits
  rdy_low_during_resp: assert property (@(posedge clk) disable iff (reset)
      resp_val |-> !req_rdy)
    else $error("req_rdy high while a response is valid");

  // stalled response keeps its value and its valid
  resp_held: assert property (@(posedge clk) disable iff (reset)
      resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else $error("response changed while stalled");

  // full iteration count before any response
  no_early_resp: assert property (@(posedge clk) disable iff (reset)
      (since_req < SAT) |-> !resp_val)
    else $error("response arrived early");

endmodule

/* tb/muldiv_tb.sv */
// -------------------------------------------------
// directed tests for the mul/div unit
// one op at a time, stops at the first mismatch
// -------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_params.svh"

module muldiv_tb import muldiv_fn_pkg::*, muldiv_result_pkg::*; ();

  localparam int XLEN    = `MULDIV_XLEN;
  localparam int ITERS   = `MULDIV_ITERS;
  localparam int TIMEOUT = 4 * `MULDIV_ITERS;

  logic            clk;
  logic            reset;
  muldiv_fn_t      req_fn;
  logic [XLEN-1:0] req_a;
  logic [XLEN-1:0] req_b;
  logic            req_val;
  logic            req_rdy;
  muldiv_result_t  resp_result;
  logic            resp_val;
  logic            resp_rdy;

  // rising edges seen so far, read at falling edges only
  int cycle_count = 0;
  int error_count = 0;

  muldiv_unit DUT (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  bind muldiv_unit muldiv_properties props (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // --------------------------------------------------
  // reference model, straight from the result rules
  // --------------------------------------------------

  function automatic logic [`MULDIV_RLEN-1:0] model_product(logic [XLEN-1:0] a,
                                                           logic [XLEN-1:0] b);
    longint sa;
    longint sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    return sa * sb;
  endfunction

  function automatic muldiv_pair_t model_divide(muldiv_fn_t fn, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
    muldiv_pair_t r;
    longint       sa;
    longint       sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (b == '0) begin
      // divide by zero, same answer signed or not
      r.quot = '1;
      r.rem  = a;
    end else if (fn == FN_DIVU) begin
      r.quot = a / b;
      r.rem  = a % b;
    end else if (a == 32'h8000_0000 && b == '1) begin
      r.quot = a;
      r.rem  = '0;
    end else begin
      // 64-bit division truncates toward zero, rem follows dividend
      r.quot = 32'(sa / sb);
      r.rem  = 32'(sa % sb);
    end
    return r;
  endfunction

  // --------------------------------------------------
  // error handling and compare tasks
  // --------------------------------------------------

  task automatic abort_run(input string line);
    error_count++;
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("Fail at %0t ns: %s", $time, msg));
  endtask

  task automatic check_product(input muldiv_result_t got, input logic [`MULDIV_RLEN-1:0] exp,
                               input string tag);
    if (got.product !== exp) begin
      report_mismatch($sformatf("%s product %h, expected %h", tag, got.product, exp));
    end
  endtask

  task automatic check_pair(input muldiv_result_t got, input muldiv_pair_t exp,
                            input string tag);
    if (got.pair.quot !== exp.quot || got.pair.rem !== exp.rem) begin
      report_mismatch($sformatf("%s quot/rem %h/%h, expected %h/%h", tag,
                                got.pair.quot, got.pair.rem, exp.quot, exp.rem));
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string tag);
    if (got != exp) begin
      report_mismatch($sformatf("%s latency %0d cycles, expected %0d", tag, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string tag);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %b, expected %b", tag, got, exp));
    end
  endtask

  // --------------------------------------------------
  // handshake tasks, entered and left on a falling edge
  // --------------------------------------------------

  task automatic send_request(input muldiv_fn_t fn, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b, output int xfer_cycle);
    int waited;
    req_fn = fn;
    req_a  = a;
    req_b  = b;
    waited = 0;
    // req_rdy is looked at only after req_fn has settled
    @(negedge clk);
    while (!req_rdy) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("timeout: the request was never accepted");
      end
      @(negedge clk);
    end
    // rdy is known high, so the transfer happens on the next rising edge
    req_val = 1'b1;
    @(negedge clk);
    req_val    = 1'b0;
    xfer_cycle = cycle_count;
  endtask

  task automatic wait_response(input int xfer_cycle, output muldiv_result_t res,
                               output int latency);
    int waited;
    waited = 0;
    while (!resp_val) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("timeout: no response arrived");
      end
      @(negedge clk);
    end
    res     = resp_result;
    latency = cycle_count - xfer_cycle;
  endtask

  task automatic check_result(input muldiv_fn_t fn, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b, input muldiv_result_t got);
    string tag;
    tag = $sformatf("fn %0d a %h b %h", fn, a, b);
    if (fn == FN_MUL) begin
      check_product(got, model_product(a, b), tag);
    end else begin
      check_pair(got, model_divide(fn, a, b), tag);
    end
  endtask

  // one full op with resp_rdy high
  task automatic run_and_check(input muldiv_fn_t fn, input logic [XLEN-1:0] a,
                               input logic [XLEN-1:0] b);
    int             xfer;
    int             latency;
    muldiv_result_t got;
    send_request(fn, a, b, xfer);
    wait_response(xfer, got, latency);
    check_cycles(latency, ITERS, "request to response");
    check_result(fn, a, b, got);
    @(negedge clk);
    check_flag(resp_val, 1'b0, "resp_val after the response transfer");
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------

  task automatic test_reset_state();
    check_flag(req_rdy, 1'b1, "req_rdy after reset");
    check_flag(resp_val, 1'b0, "resp_val after reset");
  endtask

  task automatic test_multiply();
    int i;
    run_and_check(FN_MUL, 32'd0, 32'd12345);
    run_and_check(FN_MUL, 32'd1, 32'hffff_fff9);
    run_and_check(FN_MUL, 32'hffff_ffff, 32'hffff_ffff);
    run_and_check(FN_MUL, 32'hffff_ffff, 32'd7777);
    run_and_check(FN_MUL, 32'h8000_0000, 32'h8000_0000);
    run_and_check(FN_MUL, 32'h8000_0000, 32'd1);
    run_and_check(FN_MUL, 32'hffff_fffd, 32'h7fff_ffff);
    run_and_check(FN_MUL, 32'h7fff_ffff, 32'h7fff_ffff);
    for (i = 0; i < 50; i++) begin
      run_and_check(FN_MUL, $urandom, $urandom);
    end
  endtask

  task automatic test_signed_divide();
    int i;
    run_and_check(FN_DIV, 32'd7, 32'd2);
    run_and_check(FN_DIV, 32'hffff_fff9, 32'd2);
    run_and_check(FN_DIV, 32'd7, 32'hffff_fffe);
    run_and_check(FN_DIV, 32'hffff_fff9, 32'hffff_fffe);
    run_and_check(FN_DIV, 32'h8000_0000, 32'd3);
    // overflow case
    run_and_check(FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    for (i = 0; i < 30; i++) begin
      // shorter divisors give quotients of all sizes
      run_and_check(FN_DIV, $urandom, $urandom >> $urandom_range(31, 0));
    end
  endtask

  task automatic test_unsigned_divide();
    int i;
    run_and_check(FN_DIVU, 32'hffff_ffff, 32'd3);
    run_and_check(FN_DIVU, 32'h8000_0000, 32'hffff_ffff);
    run_and_check(FN_DIVU, 32'hffff_fffe, 32'h8000_0001);
    run_and_check(FN_DIVU, 32'd3, 32'hffff_ffff);
    // divide by zero, both flavors
    run_and_check(FN_DIV, 32'hffff_fff7, 32'd0);
    run_and_check(FN_DIV, 32'h8000_0000, 32'd0);
    run_and_check(FN_DIVU, 32'hdead_beef, 32'd0);
    for (i = 0; i < 30; i++) begin
      run_and_check(FN_DIVU, $urandom, $urandom >> $urandom_range(31, 0));
    end
  endtask

  task automatic test_backpressure();
    int              k;
    int              i;
    int              hold;
    int              xfer;
    int              latency;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    muldiv_fn_t      fn;
    muldiv_result_t  held;
    for (k = 0; k < 6; k++) begin
      fn       = muldiv_fn_t'(k % 3);
      a        = $urandom;
      b        = $urandom >> $urandom_range(16, 0);
      hold     = $urandom_range(20, 1);
      resp_rdy = 1'b0;
      send_request(fn, a, b, xfer);
      wait_response(xfer, held, latency);
      check_cycles(latency, ITERS, "request to stalled response");
      for (i = 0; i < hold; i++) begin
        @(negedge clk);
        check_flag(resp_val, 1'b1, "resp_val while stalled");
        check_flag(req_rdy, 1'b0, "req_rdy while stalled");
        check_product(resp_result, held.product, "stalled response word");
      end
      resp_rdy = 1'b1;
      check_result(fn, a, b, held);
      @(negedge clk);
      check_flag(resp_val, 1'b0, "resp_val after the stalled transfer");
    end
  endtask

  task automatic test_mixed_sequence();
    int         k;
    muldiv_fn_t fn;
    for (k = 0; k < 12; k++) begin
      // mul, div, mul, divu, ...
      fn = (k % 2 == 0) ? FN_MUL : ((k % 4 == 1) ? FN_DIV : FN_DIVU);
      run_and_check(fn, $urandom, $urandom >> $urandom_range(24, 0));
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(75810));
    reset    = 1'b1;
    req_fn   = FN_MUL;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_multiply();
    test_signed_divide();
    test_unsigned_divide();
    test_backpressure();
    test_mixed_sequence();
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+common
common/muldiv_fn_pkg.sv
common/muldiv_result_pkg.sv
mul/int_mul_iterative.sv
div/int_div_iterative.sv
logic/muldiv_unit.sv
tb/muldiv_properties.sv
tb/muldiv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mul/div testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module muldiv_tb -f build.f -Mdir obj_dir -o muldiv_sim; then
  echo "ERROR: Verilator build failed"
  exit 1
fi

./obj_dir/muldiv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "RESULT: FAIL"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "RESULT: FAIL (simulator exit status $status)"
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "RESULT: FAIL (run ended without a verdict)"
  exit 1
fi
echo "RESULT: PASS"
exit 0
